/* filelist.f */
+incdir+logic
logic/video_pkg.sv
logic/vid_timing_if.sv
logic/video_timing_ctrl.sv
logic/video_regs.sv
logic/scroll_unit.sv
logic/layer_mixer.sv
logic/colour_palette.sv
logic/video_top.sv
tests/video_checker.sv
tests/video_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the video back end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module video_tb -f filelist.f

out=$(./obj_dir/Vvideo_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

/* tests/video_tb.sv */
/*
 * video back end testbench
 * random layer pixels and bus traffic checked against a cycle model
 * of the beam, scroll adders, layer priority and palette
 */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module video_tb;
	import video_pkg::*;

	localparam int      CLK_PERIOD  = 4;
	localparam int      FRAME_CYC   = `VID_HTOTAL * `VID_VTOTAL;
	localparam int      REG_ROUNDS  = 32;
	localparam int      SETUP_CYC   = 10 + 3 * 256 + 6 * (REG_ROUNDS + 4);
	localparam int      WATCHDOG_NS = (2 * FRAME_CYC + SETUP_CYC) * CLK_PERIOD * 5 / 4;
	localparam int      HBLANK_LEN  = `VID_HTOTAL - `VID_HACTIVE;
	localparam hcoord_t H_LAST      = hcoord_t'(`VID_HTOTAL - 1);
	localparam int      E_BUS = 0, E_REG = 1, E_SCROLL = 2, E_RGB = 3, E_SYNC = 4;

	logic                  pixel_clk;
	logic                  RESET_n;
	logic                  wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic [`WB_ADDR_W-1:0] wb_adr_i;
	logic [`WB_DATA_W-1:0] wb_dat_i, wb_dat_o;
	colour_idx_t           fg_pix_i, sp_pix_i, bg_pix_i;
	logic [3:0]            red_o, green_o, blue_o;
	logic                  hsync_o, vsync_o, hblank_o, vblank_o;
	hcoord_t               bg_hpos_o;
	vcoord_t               bg_vpos_o;

	// ==================================================
	// reference model state as the DUT holds it after the last edge
	hcoord_t     m_h;
	logic [8:0]  m_v;
	logic        m_flip, m_flipq;
	hcoord_t     m_sx;
	vcoord_t     m_sy;
	colour_idx_t col_m, win_prev, hot_idx, pend_idx;
	logic [3:0]  strb_q0, strb_q1;    // {hsync, vsync, hblank, vblank}
	rgb_t        pal_m [256];
	logic        pal_ok [256];
	logic        pal_pend, hb_prev, hb_seen;
	rgb_t        pend_rgb;
	logic        req_cyc, req_we;     // request driven on the next edge
	logic [`WB_ADDR_W-1:0] req_adr;
	logic [`WB_DATA_W-1:0] req_dat;
	int          errs [5];
	int          hold_fg, hb_run;

	video_top dut0 (.*);

	bind video_top video_checker chk0 (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_ack_o  (wb_ack_o),
		.hsync_o   (hsync_o),
		.vsync_o   (vsync_o),
		.hblank_o  (hblank_o),
		.vblank_o  (vblank_o)
	);

	always #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;

	function automatic colour_idx_t pick_layer(input colour_idx_t fg, input colour_idx_t sp,
	                                           input colour_idx_t bg);
		if (fg[1:0] != 2'b00)
			return fg;
		if (sp[3:0] != 4'h0)
			return sp;
		return bg;
	endfunction

	function automatic hcoord_t beam_x(input hcoord_t h, input logic f);
		return f ? H_LAST - h : h;
	endfunction

	function automatic vcoord_t beam_y(input logic [8:0] v, input logic f);
		return f ? ~v[7:0] : v[7:0];
	endfunction

	function automatic logic [3:0] window_strobes(input hcoord_t h, input logic [8:0] v);
		int hi, vi;
		hi = int'(h);
		vi = int'(v);
		return {hi >= `VID_HSYNC_START && hi < `VID_HSYNC_END,
		        vi >= `VID_VSYNC_START && vi < `VID_VSYNC_END,
		        hi >= `VID_HACTIVE, vi >= `VID_VACTIVE};
	endfunction

	function automatic logic [15:0] reg_mask(input logic [8:0] adr);
		case (int'(adr))
			`REG_SCROLL_X_LO, `REG_SCROLL_Y: return 16'h00ff;
			`REG_SCROLL_X_HI, `REG_FLIP:     return 16'h0001;
			default:                         return 16'h0000;
		endcase
	endfunction

	task automatic mismatch(input int kind, input string name, input logic [31:0] exp,
	                        input logic [31:0] act);
		errs[kind]++;
		$display("ERROR %0t %s expected %0h got %0h", $time, name, exp, act);
	endtask

	task automatic record_write(input logic [8:0] adr, input logic [15:0] dat);
		if (int'(adr) >= `PAL_BASE) begin
			pal_pend = 1'b1;
			pend_idx = adr[7:0];
			pend_rgb = rgb_t'(dat[11:0]);
		end else begin
			case (int'(adr))
				`REG_SCROLL_X_LO: m_sx[7:0] = dat[7:0];
				`REG_SCROLL_X_HI: m_sx[8]   = dat[0];
				`REG_SCROLL_Y:    m_sy      = dat[7:0];
				`REG_FLIP:        m_flip    = dat[0];
				default: ;
			endcase
		end
	endtask

	// move the model on by one edge and compare
	task automatic check_and_advance(input colour_idx_t fg, input colour_idx_t sp,
	                                 input colour_idx_t bg);
		hcoord_t exp_h;
		vcoord_t exp_v;
		rgb_t    exp_rgb;
		logic    rgb_known;
		exp_h     = beam_x(m_h, m_flipq) + m_sx;   // wraps at 512
		exp_v     = beam_y(m_v, m_flipq) + m_sy;   // wraps at 256
		exp_rgb   = pal_m[col_m];
		rgb_known = pal_ok[col_m];
		strb_q1   = strb_q0;
		strb_q0   = window_strobes(m_h, m_v);
		col_m     = win_prev;
		win_prev  = pick_layer(fg, sp, bg);
		m_flipq   = m_flip;
		if (m_h == H_LAST) begin
			m_h = '0;
			m_v = (m_v == 9'(`VID_VTOTAL - 1)) ? '0 : m_v + 9'd1;
		end else begin
			m_h = m_h + 9'd1;
		end
		// RAM write lands one edge after the ack
		if (pal_pend) begin
			pal_m[pend_idx]  = pend_rgb;
			pal_ok[pend_idx] = 1'b1;
			pal_pend         = 1'b0;
		end
		if (wb_ack_o && req_cyc && req_we)
			record_write(req_adr, req_dat);

		if (bg_hpos_o !== exp_h)
			mismatch(E_SCROLL, "bg_hpos_o", 32'(exp_h), 32'(bg_hpos_o));
		if (bg_vpos_o !== exp_v)
			mismatch(E_SCROLL, "bg_vpos_o", 32'(exp_v), 32'(bg_vpos_o));
		if (rgb_known && {red_o, green_o, blue_o} !== exp_rgb)
			mismatch(E_RGB, "red_o/green_o/blue_o", 32'(exp_rgb), 32'({red_o, green_o, blue_o}));
		if (hsync_o !== strb_q1[3])
			mismatch(E_SYNC, "hsync_o", 32'(strb_q1[3]), 32'(hsync_o));
		if (vsync_o !== strb_q1[2])
			mismatch(E_SYNC, "vsync_o", 32'(strb_q1[2]), 32'(vsync_o));
		if (hblank_o !== strb_q1[1])
			mismatch(E_SYNC, "hblank_o", 32'(strb_q1[1]), 32'(hblank_o));
		if (vblank_o !== strb_q1[0])
			mismatch(E_SYNC, "vblank_o", 32'(strb_q1[0]), 32'(vblank_o));

		// blanked pixels per line counted between edges of hblank
		if (hblank_o && !hb_prev) begin
			hb_run  = 1;
			hb_seen = 1'b1;
		end else if (hblank_o) begin
			hb_run++;
		end else if (hb_prev && hb_seen && hb_run != HBLANK_LEN) begin
			mismatch(E_SYNC, "hblank_o run length", 32'(HBLANK_LEN), 32'(hb_run));
		end
		hb_prev = hblank_o;
	endtask

	// drive on the rising edge and check on the falling edge
	task automatic step();
		colour_idx_t fg, sp, bg;
		fg = colour_idx_t'($urandom);
		sp = colour_idx_t'($urandom);
		bg = colour_idx_t'($urandom);
		if ($urandom % 4 != 0)
			fg[1:0] = 2'b00;   // mostly transparent text
		if ($urandom % 2 != 0)
			sp[3:0] = 4'h0;
		if (hold_fg > 0) begin
			fg = hot_idx;
			hold_fg--;
		end
		@(posedge pixel_clk);
		fg_pix_i <= fg;
		sp_pix_i <= sp;
		bg_pix_i <= bg;
		wb_cyc_i <= req_cyc;
		wb_stb_i <= req_cyc;
		wb_we_i  <= req_we;
		wb_adr_i <= req_adr;
		wb_dat_i <= req_dat;
		@(negedge pixel_clk);
		check_and_advance(fg, sp, bg);
	endtask

	task automatic bus_access(input logic we, input logic [8:0] adr, input logic [15:0] dat,
	                          output logic [15:0] rdat);
		int edges;
		req_cyc = 1'b1;
		req_we  = we;
		req_adr = adr;
		req_dat = dat;
		edges   = 0;
		do begin
			step();
			edges++;
		end while (!wb_ack_o && edges < 8);
		// request driven on one edge is sampled with ack on the next
		if (!wb_ack_o) begin
			errs[E_BUS]++;
			$display("bus request to address %0h was never acknowledged", adr);
		end else if (edges != 2) begin
			errs[E_BUS]++;
			$display("ack for address %0h came %0d clocks after the request", adr, edges - 1);
		end
		rdat    = wb_dat_o;
		req_cyc = 1'b0;
		step();
		if (wb_ack_o !== 1'b0) begin
			errs[E_BUS]++;
			$display("a second ack followed the request to address %0h", adr);
		end
	endtask

	// ==================================================
	// test sequence
	initial begin
		logic [15:0] rd, wr;
		logic [8:0]  adr;
		void'($urandom(32'h27f4_0d40));
		pixel_clk = 1'b0;
		RESET_n   <= 1'b0;
		{wb_cyc_i, wb_stb_i, wb_we_i} <= 3'b000;
		wb_adr_i  <= '0;
		wb_dat_i  <= '0;
		fg_pix_i  <= '0;
		sp_pix_i  <= '0;
		bg_pix_i  <= '0;
		{req_cyc, req_we, req_adr, req_dat} = '0;
		hold_fg   = 0;
		hot_idx   = '0;
		foreach (errs[i])
			errs[i] = 0;
		foreach (pal_ok[i])
			pal_ok[i] = 1'b0;

		repeat (10) @(posedge pixel_clk);
		RESET_n <= 1'b1;
		@(negedge pixel_clk);
		{m_h, m_v, m_flip, m_flipq, m_sx, m_sy} = '0;
		col_m    = '0;
		win_prev = '0;
		strb_q0  = 4'b0011;   // blanked and no sync
		strb_q1  = 4'b0011;
		pal_pend = 1'b0;
		hb_prev  = hblank_o;
		hb_seen  = 1'b0;
		hb_run   = 0;
		if ({hsync_o, vsync_o, hblank_o, vblank_o, wb_ack_o} !== 5'b00110)
			mismatch(E_SYNC, "strobes and wb_ack_o after reset", 32'h06,
			         32'({hsync_o, vsync_o, hblank_o, vblank_o, wb_ack_o}));

		for (int i = 0; i < 256; i++)
			bus_access(1'b1, 9'(`PAL_BASE + i), 16'($urandom), rd);

		for (int i = 0; i < REG_ROUNDS; i++) begin
			adr = 9'($urandom % 4);
			wr  = 16'($urandom);
			bus_access(1'b1, adr, wr, rd);
			bus_access(1'b0, adr, 16'h0, rd);
			if (rd !== (wr & reg_mask(adr)))
				mismatch(E_REG, "wb_dat_o", 32'(wr & reg_mask(adr)), 32'(rd));
		end
		for (int i = 0; i < 4; i++) begin
			adr = (i % 2 == 0) ? 9'(4 + $urandom % 252) : 9'(`PAL_BASE + $urandom % 256);
			bus_access(1'b0, adr, 16'h0, rd);
			if (rd !== 16'h0)
				mismatch(E_REG, "wb_dat_o", 32'h0, 32'(rd));
		end

		// a frame of display with scroll, flip and palette changes
		for (int n = 0; n < 40; n++) begin
			repeat (FRAME_CYC / 40) step();
			case (n % 4)
				0: begin
					bus_access(1'b1, 9'(`REG_SCROLL_X_LO), 16'($urandom), rd);
					bus_access(1'b1, 9'(`REG_SCROLL_X_HI), 16'($urandom), rd);
				end
				1: bus_access(1'b1, 9'(`REG_SCROLL_Y), 16'($urandom), rd);
				2: bus_access(1'b1, 9'(`REG_FLIP), 16'(~m_flip), rd);
				default: begin
					hot_idx = colour_idx_t'($urandom) | 8'h01;   // opaque text pixel
					hold_fg = 8;
					bus_access(1'b1, 9'(`PAL_BASE + int'(hot_idx)), 16'($urandom), rd);
				end
			endcase
		end

		$display("errors: bus %0d, registers %0d, scroll %0d, colour %0d, timing %0d",
		         errs[E_BUS], errs[E_REG], errs[E_SCROLL], errs[E_RGB], errs[E_SYNC]);
		if (errs.sum() == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the test sequence ended", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/video_checker.sv */
/*
 * video back end assertions
 * Wishbone ack handshake and sync placement inside blanking
 */
`timescale 1ns/10ps
`default_nettype none

module video_checker (
	input logic pixel_clk,
	input logic RESET_n,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o,
	input logic hsync_o,
	input logic vsync_o,
	input logic hblank_o,
	input logic vblank_o
);

	// ==================================================
	// bus handshake
	ack_one_cycle: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		wb_ack_o |=> !wb_ack_o)
		else $error("wb_ack_o stayed high for more than one clock");

	ack_after_req: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o rose without a request on the clock before");

	// ==================================================
	// sync pulses sit inside their blanking interval
	hsync_in_blank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		$rose(hsync_o) |-> hblank_o)
		else $error("hsync_o rose outside horizontal blank");

	vsync_in_blank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		$rose(vsync_o) |-> vblank_o)
		else $error("vsync_o rose outside vertical blank");

endmodule

`default_nettype wire

/* logic/video_top.sv */
/*
 * video back end top level
 * timing, cpu registers, scroll, layer mix and palette lookup
 */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module video_top (
	input  logic                   pixel_clk,
	input  logic                   RESET_n,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [`WB_ADDR_W-1:0]  wb_adr_i,
	input  logic [`WB_DATA_W-1:0]  wb_dat_i,
	output logic [`WB_DATA_W-1:0]  wb_dat_o,
	output logic                   wb_ack_o,
	input  video_pkg::colour_idx_t fg_pix_i,
	input  video_pkg::colour_idx_t sp_pix_i,
	input  video_pkg::colour_idx_t bg_pix_i,
	output logic [3:0]             red_o,
	output logic [3:0]             green_o,
	output logic [3:0]             blue_o,
	output logic                   hsync_o,
	output logic                   vsync_o,
	output logic                   hblank_o,
	output logic                   vblank_o,
	output video_pkg::hcoord_t     bg_hpos_o,
	output video_pkg::vcoord_t     bg_vpos_o
);
	import video_pkg::*;

	hcoord_t     scroll_x;
	vcoord_t     scroll_y;
	logic        flip;
	logic        pal_we;
	colour_idx_t pal_addr;
	rgb_t        pal_data;
	colour_idx_t colour;
	rgb_t        rgb;

	vid_timing_if tim0 ();

	video_timing_ctrl timing0 (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip),
		.tim       (tim0.ctrl)
	);

	video_regs regs0 (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.scroll_x_o (scroll_x),
		.scroll_y_o (scroll_y),
		.flip_o     (flip),
		.pal_we_o   (pal_we),
		.pal_addr_o (pal_addr),
		.pal_data_o (pal_data)
	);

	scroll_unit scroll0 (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.tim        (tim0.dp),
		.scroll_x_i (scroll_x),
		.scroll_y_i (scroll_y),
		.bg_hpos_o  (bg_hpos_o),
		.bg_vpos_o  (bg_vpos_o)
	);

	layer_mixer mixer0 (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.fg_pix_i  (fg_pix_i),
		.sp_pix_i  (sp_pix_i),
		.bg_pix_i  (bg_pix_i),
		.colour_o  (colour)
	);

	colour_palette palette0 (
		.pixel_clk (pixel_clk),
		.colour_i  (colour),
		.we_i      (pal_we),
		.waddr_i   (pal_addr),
		.wdata_i   (pal_data),
		.rgb_o     (rgb)
	);

	// rgb and strobes leave together, two clocks after the layer pixels
	assign red_o    = rgb.r;
	assign green_o  = rgb.g;
	assign blue_o   = rgb.b;
	assign hsync_o  = tim0.hsync_d;
	assign vsync_o  = tim0.vsync_d;
	assign hblank_o = tim0.hblank_d;
	assign vblank_o = tim0.vblank_d;

endmodule

`default_nettype wire

/* logic/colour_palette.sv */
/*
 * colour lookup RAM
 * 256 entries of 12-bit rgb, registered read, cpu write port
 */
`timescale 1ns/10ps
`default_nettype none

module colour_palette (
	input  logic                   pixel_clk,
	input  video_pkg::colour_idx_t colour_i,
	input  logic                   we_i,
	input  video_pkg::colour_idx_t waddr_i,
	input  video_pkg::rgb_t        wdata_i,
	output video_pkg::rgb_t        rgb_o
);
	import video_pkg::*;

	localparam int DEPTH = 2 ** $bits(colour_idx_t);

	rgb_t mem [DEPTH];

	// ==================================================
	// one write port, one read port
	// a write to the entry being read shows on the next lookup
	always_ff @(posedge pixel_clk) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
		rgb_o <= mem[colour_i];
	end

endmodule

`default_nettype wire

/* logic/layer_mixer.sv */
/*
 * layer priority mixer
 * foreground over sprites over background, chosen by transparency
 */
`timescale 1ns/10ps
`default_nettype none

module layer_mixer (
	input  logic                   pixel_clk,
	input  logic                   RESET_n,
	input  video_pkg::colour_idx_t fg_pix_i,
	input  video_pkg::colour_idx_t sp_pix_i,
	input  video_pkg::colour_idx_t bg_pix_i,
	output video_pkg::colour_idx_t colour_o
);
	import video_pkg::*;

	logic        fg_opaque;
	logic        sp_opaque;
	colour_idx_t winner;

	assign fg_opaque = |fg_pix_i[1:0];  // 2 bpp text layer
	assign sp_opaque = |sp_pix_i[3:0];  // 4 bpp sprites

	assign winner = fg_opaque ? fg_pix_i :
	                sp_opaque ? sp_pix_i : bg_pix_i;

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			colour_o <= '0;
		else
			colour_o <= winner;
	end

endmodule

`default_nettype wire

/* logic/scroll_unit.sv */
/*
 * background scroll adders
 * beam position plus scroll offsets, one register stage
 */
`timescale 1ns/10ps
`default_nettype none

module scroll_unit (
	input  logic               pixel_clk,
	input  logic               RESET_n,
	vid_timing_if.dp           tim,
	input  video_pkg::hcoord_t scroll_x_i,
	input  video_pkg::vcoord_t scroll_y_i,
	output video_pkg::hcoord_t bg_hpos_o,
	output video_pkg::vcoord_t bg_vpos_o
);
	import video_pkg::*;

	hcoord_t hsum;
	vcoord_t vsum;

	// both sums wrap at the coordinate width
	assign hsum = tim.hpix + scroll_x_i;  // mod 512
	assign vsum = tim.vpix + scroll_y_i;  // mod 256

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			bg_hpos_o <= '0;
			bg_vpos_o <= '0;
		end else begin
			bg_hpos_o <= hsum;
			bg_vpos_o <= vsum;
		end
	end

endmodule

`default_nettype wire

/* logic/video_regs.sv */
/*
 * cpu register block, Wishbone classic slave
 * scroll and flip registers, palette writes turned into a write strobe
 */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module video_regs (
	input  logic                    pixel_clk,
	input  logic                    RESET_n,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  logic [`WB_ADDR_W-1:0]   wb_adr_i,
	input  logic [`WB_DATA_W-1:0]   wb_dat_i,
	output logic [`WB_DATA_W-1:0]   wb_dat_o,
	output logic                    wb_ack_o,
	output video_pkg::hcoord_t      scroll_x_o,
	output video_pkg::vcoord_t      scroll_y_o,
	output logic                    flip_o,
	output logic                    pal_we_o,
	output video_pkg::colour_idx_t  pal_addr_o,
	output video_pkg::rgb_t         pal_data_o
);
	import video_pkg::*;

	localparam logic [`WB_ADDR_W-1:0] A_SX_LO = `WB_ADDR_W'(`REG_SCROLL_X_LO);
	localparam logic [`WB_ADDR_W-1:0] A_SX_HI = `WB_ADDR_W'(`REG_SCROLL_X_HI);
	localparam logic [`WB_ADDR_W-1:0] A_SY    = `WB_ADDR_W'(`REG_SCROLL_Y);
	localparam logic [`WB_ADDR_W-1:0] A_FLIP  = `WB_ADDR_W'(`REG_FLIP);
	localparam logic [`WB_ADDR_W-1:0] A_PAL   = `WB_ADDR_W'(`PAL_BASE);

	logic                  req;
	logic                  pal_sel;
	logic [7:0]            sx_lo;
	logic                  sx_hi;   // ninth scroll bit sits in its own latch on the board
	logic [`WB_DATA_W-1:0] rd_data;

	// ack already high means this request is being answered
	assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign pal_sel = wb_adr_i >= A_PAL;

	always_comb begin
		case (wb_adr_i)
			A_SX_LO: rd_data = `WB_DATA_W'(sx_lo);
			A_SX_HI: rd_data = `WB_DATA_W'(sx_hi);
			A_SY:    rd_data = `WB_DATA_W'(scroll_y_o);
			A_FLIP:  rd_data = `WB_DATA_W'(flip_o);
			default: rd_data = '0;  // palette is write only
		endcase
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			wb_ack_o   <= 1'b0;
			pal_we_o   <= 1'b0;
			sx_lo      <= '0;
			sx_hi      <= 1'b0;
			scroll_y_o <= '0;
			flip_o     <= 1'b0;
		end else begin
			wb_ack_o <= req;
			pal_we_o <= req && wb_we_i && pal_sel;
			if (req && wb_we_i) begin
				case (wb_adr_i)
					A_SX_LO: sx_lo      <= wb_dat_i[7:0];
					A_SX_HI: sx_hi      <= wb_dat_i[0];
					A_SY:    scroll_y_o <= wb_dat_i[7:0];
					A_FLIP:  flip_o     <= wb_dat_i[0];
					default: ;
				endcase
			end
		end
	end

	// data paths, qualified by ack and pal_we
	always_ff @(posedge pixel_clk) begin
		if (req && !wb_we_i)
			wb_dat_o <= rd_data;
		if (req && wb_we_i && pal_sel) begin
			pal_addr_o <= wb_adr_i[7:0];
			pal_data_o <= rgb_t'(wb_dat_i[11:0]);  // r 11:8, g 7:4, b 3:0
		end
	end

	assign scroll_x_o = {sx_hi, sx_lo};

endmodule

`default_nettype wire

/* logic/video_timing_ctrl.sv */
/*
 * video timing controller
 * line and frame counters, screen flip mapping and sync/blank decode,
 * with the strobes delayed to line up with the rgb output
 */
`timescale 1ns/10ps
`default_nettype none
`include "video_cfg.svh"

module video_timing_ctrl (
	input  logic       pixel_clk,
	input  logic       RESET_n,
	input  logic       flip_i,
	vid_timing_if.ctrl tim
);
	import video_pkg::*;

	localparam hcoord_t    H_LAST    = hcoord_t'(`VID_HTOTAL - 1);
	localparam logic [8:0] V_LAST    = 9'(`VID_VTOTAL - 1);
	localparam logic [3:0] STRB_IDLE = 4'b0011;  // blanked, no sync

	hcoord_t    hcnt;
	logic [8:0] vcnt;   // 264 lines need the ninth bit
	logic       flip_q;
	logic [3:0] raw;    // {hsync, vsync, hblank, vblank}
	logic [3:0] dly [`VID_PIPE_DEPTH];

	// ==================================================
	// beam counters
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == H_LAST) begin
			hcnt <= '0;
			vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 9'd1;
		end else begin
			hcnt <= hcnt + 9'd1;
		end
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			flip_q <= 1'b0;
		else
			flip_q <= flip_i;  // new flip seen one clock after the write
	end

	// mirrored screen counts down on both axes
	assign tim.flip = flip_q;
	assign tim.hpix = flip_q ? H_LAST - hcnt : hcnt;
	assign tim.vpix = flip_q ? ~vcnt[7:0] : vcnt[7:0];

	// ==================================================
	// sync and blank windows on the raw counters
	assign raw[3] = (hcnt >= hcoord_t'(`VID_HSYNC_START)) && (hcnt < hcoord_t'(`VID_HSYNC_END));
	assign raw[2] = (vcnt >= 9'(`VID_VSYNC_START)) && (vcnt < 9'(`VID_VSYNC_END));
	assign raw[1] = hcnt >= hcoord_t'(`VID_HACTIVE);
	assign raw[0] = vcnt >= 9'(`VID_VACTIVE);

	// delay line, same depth as mixer plus palette
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			for (int i = 0; i < `VID_PIPE_DEPTH; i++) begin
				dly[i] <= STRB_IDLE;
			end
		end else begin
			dly[0] <= raw;
			for (int i = 1; i < `VID_PIPE_DEPTH; i++) begin
				dly[i] <= dly[i-1];
			end
		end
	end

	assign tim.hsync_d  = dly[`VID_PIPE_DEPTH-1][3];
	assign tim.vsync_d  = dly[`VID_PIPE_DEPTH-1][2];
	assign tim.hblank_d = dly[`VID_PIPE_DEPTH-1][1];
	assign tim.vblank_d = dly[`VID_PIPE_DEPTH-1][0];

endmodule

`default_nettype wire

/* logic/vid_timing_if.sv */
/*
 * beam timing bundle
 * flip-mapped position plus the delayed sync and blank strobes
 */
`timescale 1ns/10ps
`default_nettype none

interface vid_timing_if;
	import video_pkg::*;

	hcoord_t hpix;      // flip-mapped beam x
	vcoord_t vpix;      // flip-mapped beam y
	logic    flip;
	logic    hblank_d;  // strobes below already match the pixel pipe
	logic    vblank_d;
	logic    hsync_d;
	logic    vsync_d;

	modport ctrl (output hpix, vpix, flip, hblank_d, vblank_d, hsync_d, vsync_d);
	modport dp   (input  hpix, vpix, flip, hblank_d, vblank_d, hsync_d, vsync_d);

endinterface

`default_nettype wire

/* logic/video_pkg.sv */
/*
 * video types
 * beam coordinates, palette index and 12-bit rgb colour
 */
`default_nettype none

package video_pkg;

	// horizontal beam position, 0..383 fits in 9 bits
	typedef logic [8:0] hcoord_t;

	// vertical beam position, low byte of the line counter
	typedef logic [7:0] vcoord_t;

	// palette index as delivered by the layers
	// low bits zero means a transparent pixel
	typedef logic [7:0] colour_idx_t;

	// one palette entry, red in the top nibble
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

endpackage

`default_nettype wire

/* logic/video_cfg.svh */
/*
 * video back end configuration
 * frame geometry, register map, bus widths and pipeline depth
 */
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// ==================================================
// frame geometry, in pixel_clk ticks and lines
`define VID_HTOTAL       384
`define VID_HACTIVE      256
`define VID_HSYNC_START  296
`define VID_HSYNC_END    328
`define VID_VTOTAL       264
`define VID_VACTIVE      224
`define VID_VSYNC_START  240
`define VID_VSYNC_END    243
`define VID_PIPE_DEPTH   2      // pixel in to rgb out

// ==================================================
// cpu register map, word addresses
`define REG_SCROLL_X_LO  0
`define REG_SCROLL_X_HI  1
`define REG_SCROLL_Y     2
`define REG_FLIP         3
`define PAL_BASE         256    // palette window up to the top of the bus
`define WB_ADDR_W        9
`define WB_DATA_W        16

`endif
